/* PeripheralPkg.sv */
package PeripheralPkg;

	// Bus and data widths
	typedef logic [31:0] busAddrT;
	typedef logic [31:0] wordT;
	typedef logic [3:0] strobeT;

	// Video RAM widths
	typedef logic [7:0] pixelT;
	typedef logic [10:0] scanAddrT;
	// MSB picks the buffer half
	typedef logic [9:0] bankWordAddrT;

	// Region codes from the address decoder
	typedef logic [2:0] regionT;

	localparam regionT REGION_NONE = 3'd0;
	localparam regionT REGION_SEVEN_SEG = 3'd1;
	localparam regionT REGION_BOOT = 3'd2;
	localparam regionT REGION_MICROS = 3'd3;
	localparam regionT REGION_MILLIS = 3'd4;
	localparam regionT REGION_BUFFER_CTRL = 3'd5;
	localparam regionT REGION_VRAM = 3'd6;

	// Register map, word aligned
	localparam busAddrT SEVEN_SEG_ADDR = 32'h100;
	localparam busAddrT BOOT_ADDR = 32'h104;
	localparam busAddrT MICROS_ADDR = 32'h10C;
	localparam busAddrT MILLIS_ADDR = 32'h110;
	localparam busAddrT BUFFER_CTRL_ADDR = 32'h114;

	// Video banks sit back to back from the base
	localparam busAddrT VRAM_BASE = 32'h10000;
	localparam logic [31:0] VRAM_BANK_BYTES = 32'h800;

	// Upper and lower panel halves
	localparam int NUM_BANKS = 2;

endpackage

/* AxiLiteSlave.sv */
module AxiLiteSlave (
	input logic clk,
	input logic rst,

	// Write address and data channels
	input PeripheralPkg::busAddrT awaddr,
	input logic awvalid,
	output logic awready,
	input PeripheralPkg::wordT wdata,
	input PeripheralPkg::strobeT wstrb,
	input logic wvalid,
	output logic wready,

	// Write response channel
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,

	// Read channels
	input PeripheralPkg::busAddrT araddr,
	input logic arvalid,
	output logic arready,
	output PeripheralPkg::wordT rdata,
	output logic rvalid,
	input logic rready,
	output logic [1:0] rresp,

	// Single-cycle access toward the peripherals
	output logic accessValid,
	output logic accessWrite,
	output PeripheralPkg::busAddrT accessAddress,
	output PeripheralPkg::wordT accessData,
	output PeripheralPkg::strobeT accessStrobe,
	input PeripheralPkg::wordT readData
);

	// Cycles from the arready handshake to the rdata capture edge, plus one
	localparam int READ_LATENCY = 2;
	localparam logic [1:0] LAST_WAIT = 2'(READ_LATENCY - 1);

	typedef enum logic [1:0] {
		IDLE,
		WRITE_RESP,
		READ_WAIT,
		READ_RESP
	} busStateT;

	busStateT state;
	logic [1:0] waitCount;
	logic writeAccept;
	logic readAccept;
	logic readDone;

	always_comb begin
		// A write with both channels valid wins over a read
		writeAccept = (state == IDLE) && awvalid && wvalid;
		readAccept = (state == IDLE) && arvalid && !writeAccept;
		readDone = (state == READ_WAIT) && (waitCount == LAST_WAIT);
	end

	assign awready = writeAccept;
	assign wready = writeAccept;
	assign arready = readAccept;

	assign accessValid = writeAccept || readAccept;
	assign accessWrite = writeAccept;
	assign accessAddress = writeAccept ? awaddr : araddr;
	assign accessData = wdata;
	assign accessStrobe = wstrb;

	// Responses are always OKAY
	assign bvalid = (state == WRITE_RESP);
	assign bresp = 2'b00;
	assign rvalid = (state == READ_RESP);
	assign rresp = 2'b00;

	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			state <= IDLE;
			waitCount <= 2'd0;
		end else begin
			case (state)
				IDLE: begin
					if (writeAccept) begin
						state <= WRITE_RESP;
					end else if (readAccept) begin
						state <= READ_WAIT;
						// The handshake cycle counts as the first
						waitCount <= 2'd1;
					end
				end
				WRITE_RESP: begin
					if (bready) begin
						state <= IDLE;
					end
				end
				READ_WAIT: begin
					if (readDone) begin
						state <= READ_RESP;
					end else begin
						waitCount <= waitCount + 2'd1;
					end
				end
				READ_RESP: begin
					if (rready) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Held until the master takes it
	always_ff @(posedge clk) begin
		if (readDone) begin
			rdata <= readData;
		end
	end

endmodule

/* AddressDecoder.sv */
module AddressDecoder (
	input logic clk,
	input logic rst,
	input logic accessValid,
	input logic accessWrite,
	input PeripheralPkg::busAddrT accessAddress,
	input PeripheralPkg::strobeT accessStrobe,
	output logic [PeripheralPkg::NUM_BANKS-1:0] bankWrite,
	output logic [$bits(PeripheralPkg::bankWordAddrT)-2:0] bankWordAddr,
	output logic regWrite,
	output PeripheralPkg::regionT regionSel,
	output logic [$clog2(PeripheralPkg::NUM_BANKS)-1:0] bankSel
);

	import PeripheralPkg::*;

	localparam int BANK_BYTE_BITS = $clog2(VRAM_BANK_BYTES);
	localparam int BANK_SEL_BITS = $clog2(NUM_BANKS);
	localparam busAddrT VRAM_END = busAddrT'(VRAM_BASE + NUM_BANKS * VRAM_BANK_BYTES);

	busAddrT vramOffset;
	regionT region;
	logic [BANK_SEL_BITS-1:0] bankIndex;
	logic writeAccess;
	logic readAccess;

	always_comb begin
		vramOffset = accessAddress - VRAM_BASE;
		bankIndex = vramOffset[BANK_BYTE_BITS +: BANK_SEL_BITS];
		bankWordAddr = vramOffset[BANK_BYTE_BITS-1:2];

		if (accessAddress == SEVEN_SEG_ADDR) begin
			region = REGION_SEVEN_SEG;
		end else if (accessAddress == BOOT_ADDR) begin
			region = REGION_BOOT;
		end else if (accessAddress == MICROS_ADDR) begin
			region = REGION_MICROS;
		end else if (accessAddress == MILLIS_ADDR) begin
			region = REGION_MILLIS;
		end else if (accessAddress == BUFFER_CTRL_ADDR) begin
			region = REGION_BUFFER_CTRL;
		end else if (accessAddress >= VRAM_BASE && accessAddress < VRAM_END) begin
			region = REGION_VRAM;
		end else begin
			region = REGION_NONE;
		end
	end

	always_comb begin
		// A write with no byte lanes set changes nothing
		writeAccess = accessValid && accessWrite && (accessStrobe != '0);
		readAccess = accessValid && !accessWrite;

		// Counters are read only
		regWrite = writeAccess && (region == REGION_SEVEN_SEG || region == REGION_BOOT
			|| region == REGION_BUFFER_CTRL);

		for (int i = 0; i < NUM_BANKS; i++) begin
			bankWrite[i] = writeAccess && (region == REGION_VRAM)
				&& (bankIndex == BANK_SEL_BITS'(i));
		end
	end

	// Lines up with the registered bank read
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			regionSel <= REGION_NONE;
			bankSel <= '0;
		end else if (readAccess) begin
			regionSel <= region;
			bankSel <= bankIndex;
		end else begin
			regionSel <= REGION_NONE;
		end
	end

endmodule

/* VideoBank.sv */
module VideoBank (
	input logic clk,
	input logic bankWrite,
	input logic [$bits(PeripheralPkg::bankWordAddrT)-2:0] bankWordAddr,
	input PeripheralPkg::wordT accessData,
	input PeripheralPkg::strobeT accessStrobe,
	input logic displayBuffer,
	input PeripheralPkg::scanAddrT scanAddress,
	output PeripheralPkg::wordT bankData,
	output PeripheralPkg::pixelT pixel
);

	import PeripheralPkg::*;

	localparam int WORDS = 2 ** $bits(bankWordAddrT);
	localparam int BYTE_BITS = $bits(pixelT);

	wordT ram [WORDS];

	bankWordAddrT busWordAddr;
	bankWordAddrT scanWordAddr;
	wordT scanWord;
	logic [1:0] scanByte;

	always_comb begin
		// Bus side always lands in the offscreen half
		busWordAddr = {~displayBuffer, bankWordAddr};
		scanWordAddr = {displayBuffer, scanAddress[$bits(scanAddrT)-1:2]};
	end

	// Bus port with byte lanes
	always_ff @(posedge clk) begin
		if (bankWrite) begin
			for (int b = 0; b < $bits(strobeT); b++) begin
				if (accessStrobe[b]) begin
					ram[busWordAddr][BYTE_BITS*b +: BYTE_BITS] <= accessData[BYTE_BITS*b +: BYTE_BITS];
				end
			end
		end
		bankData <= ram[busWordAddr];
	end

	// Scan port, byte index kept for the select
	always_ff @(posedge clk) begin
		scanWord <= ram[scanWordAddr];
		scanByte <= scanAddress[1:0];
	end

	assign pixel = scanWord[BYTE_BITS*scanByte +: BYTE_BITS];

endmodule

/* ControlRegisters.sv */
module ControlRegisters #(
	parameter PeripheralPkg::busAddrT RESET_BOOT_ADDRESS = 32'h3FC
) (
	input logic clk,
	input logic rst,
	input logic regWrite,
	input PeripheralPkg::busAddrT accessAddress,
	input PeripheralPkg::wordT accessData,
	input logic frameDone,
	output PeripheralPkg::wordT sevenSegment,
	output PeripheralPkg::busAddrT bootAddress,
	output logic swapRequest,
	output logic displayBuffer
);

	import PeripheralPkg::*;

	logic swapNow;

	// Swap only between frames, never mid-scan
	assign swapNow = frameDone && swapRequest;

	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			sevenSegment <= '0;
			bootAddress <= RESET_BOOT_ADDRESS;
			swapRequest <= 1'b0;
			displayBuffer <= 1'b0;
		end else begin
			if (swapNow) begin
				displayBuffer <= ~displayBuffer;
				swapRequest <= 1'b0;
			end

			// A request written in the swap cycle stays armed for the next frame
			if (regWrite) begin
				if (accessAddress == SEVEN_SEG_ADDR) begin
					sevenSegment <= accessData;
				end else if (accessAddress == BOOT_ADDR) begin
					bootAddress <= accessData;
				end else if (accessAddress == BUFFER_CTRL_ADDR) begin
					swapRequest <= accessData[0];
				end
			end
		end
	end

endmodule

/* TimeBase.sv */
module TimeBase #(
	parameter int TICKS_PER_MICROSECOND = 8
) (
	input logic clk,
	input logic rst,
	output PeripheralPkg::wordT micros,
	output PeripheralPkg::wordT millis
);

	localparam int CYCLE_BITS = (TICKS_PER_MICROSECOND > 1) ? $clog2(TICKS_PER_MICROSECOND) : 1;
	localparam int MICROS_PER_MILLI = 1000;
	localparam int MICRO_BITS = $clog2(MICROS_PER_MILLI);

	logic [CYCLE_BITS-1:0] cycleCount;
	logic [MICRO_BITS-1:0] microCount;
	logic microTick;

	assign microTick = (cycleCount == CYCLE_BITS'(TICKS_PER_MICROSECOND - 1));

	// Both counters wrap at 32 bits
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			cycleCount <= '0;
			microCount <= '0;
			micros <= '0;
			millis <= '0;
		end else begin
			cycleCount <= microTick ? '0 : cycleCount + 1'b1;
			if (microTick) begin
				micros <= micros + 32'd1;
				if (microCount == MICRO_BITS'(MICROS_PER_MILLI - 1)) begin
					microCount <= '0;
					millis <= millis + 32'd1;
				end else begin
					microCount <= microCount + 1'b1;
				end
			end
		end
	end

endmodule

/* ReadMux.sv */
module ReadMux (
	input PeripheralPkg::regionT regionSel,
	input logic [$clog2(PeripheralPkg::NUM_BANKS)-1:0] bankSel,
	input PeripheralPkg::wordT [PeripheralPkg::NUM_BANKS-1:0] bankData,
	input PeripheralPkg::wordT sevenSegment,
	input PeripheralPkg::busAddrT bootAddress,
	input PeripheralPkg::wordT micros,
	input PeripheralPkg::wordT millis,
	input logic swapRequest,
	input logic displayBuffer,
	output PeripheralPkg::wordT readData
);

	import PeripheralPkg::*;

	always_comb begin
		case (regionSel)
			REGION_SEVEN_SEG: readData = sevenSegment;
			REGION_BOOT: readData = bootAddress;
			REGION_MICROS: readData = micros;
			REGION_MILLIS: readData = millis;
			// Bit 1 is the shown half, bit 0 the pending swap
			REGION_BUFFER_CTRL: readData = {30'd0, displayBuffer, swapRequest};
			REGION_VRAM: readData = bankData[bankSel];
			// Unmapped reads return zero
			default: readData = '0;
		endcase
	end

endmodule

/* PeripheralBus.sv */
module PeripheralBus #(
	parameter int TICKS_PER_MICROSECOND = 8,
	parameter PeripheralPkg::busAddrT RESET_BOOT_ADDRESS = 32'h3FC
) (
	input logic clk,
	input logic rst,

	// AXI4-Lite slave
	input PeripheralPkg::busAddrT awaddr,
	input logic awvalid,
	output logic awready,
	input PeripheralPkg::wordT wdata,
	input PeripheralPkg::strobeT wstrb,
	input logic wvalid,
	output logic wready,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input PeripheralPkg::busAddrT araddr,
	input logic arvalid,
	output logic arready,
	output PeripheralPkg::wordT rdata,
	output logic rvalid,
	input logic rready,
	output logic [1:0] rresp,

	// Display side
	input PeripheralPkg::scanAddrT scanAddress,
	input logic frameDone,
	output PeripheralPkg::pixelT pixelUpper,
	output PeripheralPkg::pixelT pixelLower,
	output PeripheralPkg::wordT sevenSegment,
	output PeripheralPkg::busAddrT bootAddress
);

	import PeripheralPkg::*;

	logic accessValid;
	logic accessWrite;
	busAddrT accessAddress;
	wordT accessData;
	strobeT accessStrobe;
	wordT readData;

	logic [NUM_BANKS-1:0] bankWrite;
	logic [$bits(bankWordAddrT)-2:0] bankWordAddr;
	logic regWrite;
	regionT regionSel;
	logic [$clog2(NUM_BANKS)-1:0] bankSel;

	wordT [NUM_BANKS-1:0] bankData;
	pixelT [NUM_BANKS-1:0] bankPixel;

	logic swapRequest;
	logic displayBuffer;
	wordT micros;
	wordT millis;

	AxiLiteSlave slave_i (
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rready(rready),
		.rresp(rresp),
		.accessValid(accessValid),
		.accessWrite(accessWrite),
		.accessAddress(accessAddress),
		.accessData(accessData),
		.accessStrobe(accessStrobe),
		.readData(readData)
	);

	AddressDecoder decoder_i (
		.clk(clk),
		.rst(rst),
		.accessValid(accessValid),
		.accessWrite(accessWrite),
		.accessAddress(accessAddress),
		.accessStrobe(accessStrobe),
		.bankWrite(bankWrite),
		.bankWordAddr(bankWordAddr),
		.regWrite(regWrite),
		.regionSel(regionSel),
		.bankSel(bankSel)
	);

	// Bank 0 feeds the upper panel half, bank 1 the lower
	for (genvar i = 0; i < NUM_BANKS; i++) begin : genBank
		VideoBank bank_i (
			.clk(clk),
			.bankWrite(bankWrite[i]),
			.bankWordAddr(bankWordAddr),
			.accessData(accessData),
			.accessStrobe(accessStrobe),
			.displayBuffer(displayBuffer),
			.scanAddress(scanAddress),
			.bankData(bankData[i]),
			.pixel(bankPixel[i])
		);
	end

	assign pixelUpper = bankPixel[0];
	assign pixelLower = bankPixel[1];

	ControlRegisters #(
		.RESET_BOOT_ADDRESS(RESET_BOOT_ADDRESS)
	) regs_i (
		.clk(clk),
		.rst(rst),
		.regWrite(regWrite),
		.accessAddress(accessAddress),
		.accessData(accessData),
		.frameDone(frameDone),
		.sevenSegment(sevenSegment),
		.bootAddress(bootAddress),
		.swapRequest(swapRequest),
		.displayBuffer(displayBuffer)
	);

	TimeBase #(
		.TICKS_PER_MICROSECOND(TICKS_PER_MICROSECOND)
	) timeBase_i (
		.clk(clk),
		.rst(rst),
		.micros(micros),
		.millis(millis)
	);

	ReadMux readMux_i (
		.regionSel(regionSel),
		.bankSel(bankSel),
		.bankData(bankData),
		.sevenSegment(sevenSegment),
		.bootAddress(bootAddress),
		.micros(micros),
		.millis(millis),
		.swapRequest(swapRequest),
		.displayBuffer(displayBuffer),
		.readData(readData)
	);

endmodule

/* PeripheralBusTb.sv */
module PeripheralBusTb;

	timeunit 1ns;
	timeprecision 1ps;

	import PeripheralPkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int TICKS = 4;
	localparam int SCAN_WORDS = 8;
	localparam int STALL_LOOPS = 4;
	localparam int TIME_SAMPLES = 4;
	localparam int TIME_GAP_MAX = 2500;
	// Rough cycle count of the bus and scan tests plus the time base gaps
	localparam int TEST_CYCLES = RESET_CYCLES + 2000 + TIME_SAMPLES * (TIME_GAP_MAX + 60);
	localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

	logic clk;
	logic rst;
	busAddrT awaddr;
	logic awvalid;
	logic awready;
	wordT wdata;
	strobeT wstrb;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	busAddrT araddr;
	logic arvalid;
	logic arready;
	wordT rdata;
	logic rvalid;
	logic rready;
	logic [1:0] rresp;
	scanAddrT scanAddress;
	logic frameDone;
	pixelT pixelUpper;
	pixelT pixelLower;
	wordT sevenSegment;
	busAddrT bootAddress;

	int valueErrors = 0;
	int protocolErrors = 0;
	int cycleCount = 0;
	int arCycle = 0;

	// Reference model of the video halves and the swap control
	wordT vramModel [NUM_BANKS][2][SCAN_WORDS];
	logic shownHalf;
	logic swapPending;

	logic prevBvalid;
	logic prevBready;
	logic prevRvalid;
	logic prevRready;
	wordT prevRdata;
	logic [1:0] arHistory;

	PeripheralBus #(
		.TICKS_PER_MICROSECOND(TICKS),
		.RESET_BOOT_ADDRESS(32'h3FC)
	) dut_i (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic reportProtocol(input string msg);
		protocolErrors++;
		$display("Protocol failure at %0t: %s", $time, msg);
	endtask

	// Channel rules, sampled before the DUT updates on each edge
	always @(posedge clk) begin
		cycleCount++;
		if (rst == 1'b0) begin
			prevBvalid = 1'b0;
			prevBready = 1'b0;
			prevRvalid = 1'b0;
			prevRready = 1'b0;
			arHistory = 2'b00;
		end else begin
			if (prevBvalid && !prevBready) begin
				assert (bvalid) else reportProtocol("bvalid dropped before the master took it");
			end
			if (prevRvalid && !prevRready) begin
				assert (rvalid && rdata === prevRdata)
					else reportProtocol("read response changed before the master took it");
			end
			assert ((rvalid && !prevRvalid) == arHistory[1])
				else reportProtocol("rvalid did not rise two cycles after the arready handshake");
			assert (!((bvalid || rvalid) && (awready || arready)))
				else reportProtocol("a new transaction was accepted during a pending response");
			assert (wready === awready)
				else reportProtocol("wready and awready were not raised together");
			assert (bresp == 2'b00 && rresp == 2'b00)
				else reportProtocol("a response code was not OKAY");
			if (arready) begin
				arCycle = cycleCount;
			end
			prevBvalid = bvalid;
			prevBready = bready;
			prevRvalid = rvalid;
			prevRready = rready;
			prevRdata = rdata;
			arHistory = {arHistory[0], arready};
		end
	end

	task automatic checkWord(input string what, input wordT got, input wordT expected);
		assert (got === expected) else begin
			valueErrors++;
			$display("error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, expected);
		end
	endtask

	function automatic busAddrT vramAddr(input int bank, input int word);
		return VRAM_BASE + VRAM_BANK_BYTES * busAddrT'(bank) + busAddrT'(4 * word);
	endfunction

	// AXI byte lanes applied to the model word
	function automatic wordT mergeBytes(input wordT old, input wordT data, input strobeT strb);
		wordT result;
		result = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				result[8*b +: 8] = data[8*b +: 8];
			end
		end
		return result;
	endfunction

	function automatic wordT bufferCtrlValue();
		return {30'd0, shownHalf, swapPending};
	endfunction

	task automatic writeBus(input busAddrT addr, input wordT data, input strobeT strb);
		int stall;
		stall = $urandom_range(4, 0);
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(posedge clk);
		while (!awready) @(posedge clk);
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		repeat (stall) @(negedge clk);
		bready = 1'b1;
		@(posedge clk);
		while (!bvalid) @(posedge clk);
		@(negedge clk);
		bready = 1'b0;
	endtask

	// Expects arvalid already raised
	task automatic finishRead(output wordT data);
		int stall;
		stall = $urandom_range(4, 0);
		@(posedge clk);
		while (!arready) @(posedge clk);
		@(negedge clk);
		arvalid = 1'b0;
		repeat (stall) @(negedge clk);
		rready = 1'b1;
		@(posedge clk);
		while (!rvalid) @(posedge clk);
		data = rdata;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic readBus(input busAddrT addr, output wordT data);
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		finishRead(data);
	endtask

	task automatic readCheck(input busAddrT addr, input wordT expected, input string what);
		wordT data;
		readBus(addr, data);
		checkWord(what, data, expected);
	endtask

	// Bus writes land in the half not on display
	task automatic writeVram(input int bank, input int word, input wordT data, input strobeT strb);
		logic half;
		half = ~shownHalf;
		vramModel[bank][half][word] = mergeBytes(vramModel[bank][half][word], data, strb);
		writeBus(vramAddr(bank, word), data, strb);
	endtask

	task automatic fillOffscreen();
		for (int b = 0; b < NUM_BANKS; b++) begin
			for (int w = 0; w < SCAN_WORDS; w++) begin
				writeVram(b, w, $urandom, 4'hF);
			end
		end
		for (int b = 0; b < NUM_BANKS; b++) begin
			for (int w = 0; w < SCAN_WORDS; w++) begin
				readCheck(vramAddr(b, w), vramModel[b][~shownHalf][w], "VRAM readback");
			end
		end
	endtask

	// Every byte of the displayed words in both panel halves
	task automatic checkScan();
		for (int w = 0; w < SCAN_WORDS; w++) begin
			for (int b = 0; b < 4; b++) begin
				@(negedge clk);
				scanAddress = scanAddrT'(w * 4 + b);
				@(negedge clk);
				checkWord($sformatf("pixelUpper at scan %0d", w * 4 + b), wordT'(pixelUpper),
					wordT'(vramModel[0][shownHalf][w][8*b +: 8]));
				checkWord($sformatf("pixelLower at scan %0d", w * 4 + b), wordT'(pixelLower),
					wordT'(vramModel[1][shownHalf][w][8*b +: 8]));
			end
		end
	endtask

	task automatic requestSwap();
		writeBus(BUFFER_CTRL_ADDR, 32'h1, 4'hF);
		swapPending = 1'b1;
		readCheck(BUFFER_CTRL_ADDR, bufferCtrlValue(), "buffer control with swap pending");
	endtask

	task automatic endFrame();
		@(negedge clk);
		frameDone = 1'b1;
		@(negedge clk);
		frameDone = 1'b0;
		if (swapPending) begin
			shownHalf = ~shownHalf;
			swapPending = 1'b0;
		end
		readCheck(BUFFER_CTRL_ADDR, bufferCtrlValue(), "buffer control after frame end");
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the test did not finish", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		wordT value;
		wordT readValue;
		wordT firstMicros;
		wordT secondMicros;
		wordT millisValue;
		int firstCycle;
		int gap;
		int delta;

		void'($urandom(32'h3a92));
		$timeformat(-9, 0, " ns", 0);
		clk = 1'b0;
		rst = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		scanAddress = '0;
		frameDone = 1'b0;
		shownHalf = 1'b0;
		swapPending = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b1;

		// Reset state
		@(negedge clk);
		checkWord("sevenSegment after reset", sevenSegment, 32'h0);
		checkWord("bootAddress after reset", bootAddress, 32'h3FC);
		readCheck(BUFFER_CTRL_ADDR, 32'h0, "buffer control after reset");

		// Registers, byte merge and unmapped space
		for (int i = 0; i < 3; i++) begin
			value = $urandom;
			writeBus(SEVEN_SEG_ADDR, value, 4'hF);
			checkWord("sevenSegment output", sevenSegment, value);
			readCheck(SEVEN_SEG_ADDR, value, "sevenSegment readback");
			value = $urandom;
			writeBus(BOOT_ADDR, value, 4'hF);
			checkWord("bootAddress output", bootAddress, value);
			readCheck(BOOT_ADDR, value, "bootAddress readback");
		end
		writeVram(0, 4, $urandom, 4'hF);
		writeVram(0, 4, $urandom, 4'b0101);
		readCheck(vramAddr(0, 4), vramModel[0][~shownHalf][4], "VRAM merged word");
		writeVram(1, 4, $urandom, 4'hF);
		writeVram(1, 4, $urandom, 4'b1010);
		readCheck(vramAddr(1, 4), vramModel[1][~shownHalf][4], "VRAM merged word");
		writeBus(32'h108, $urandom, 4'hF);
		readCheck(32'h108, 32'h0, "unmapped register");
		readCheck(32'h0, 32'h0, "unmapped low address");
		readCheck(vramAddr(NUM_BANKS, 0), 32'h0, "address past the video banks");

		// Double buffering and byte selection
		fillOffscreen();
		endFrame();
		requestSwap();
		endFrame();
		checkScan();
		for (int i = 0; i < 2; i++) begin
			fillOffscreen();
			checkScan();
			requestSwap();
			checkScan();
			endFrame();
			checkScan();
		end

		// Time base
		for (int i = 0; i < TIME_SAMPLES; i++) begin
			readBus(MICROS_ADDR, firstMicros);
			firstCycle = arCycle;
			repeat ($urandom_range(TIME_GAP_MAX, 100)) @(negedge clk);
			readBus(MILLIS_ADDR, millisValue);
			readBus(MICROS_ADDR, secondMicros);
			gap = arCycle - firstCycle;
			delta = int'(secondMicros - firstMicros);
			assert (delta >= gap / TICKS - 1 && delta <= gap / TICKS + 1) else begin
				valueErrors++;
				$display("error at %0t: micros advanced %0d in %0d cycles", $time, delta, gap);
			end
			assert (millisValue == secondMicros / 32'd1000
				|| millisValue + 32'd1 == secondMicros / 32'd1000) else begin
				valueErrors++;
				$display("error at %0t: millis %0d does not follow micros %0d", $time,
					millisValue, secondMicros);
			end
		end

		// A read held behind a stalled write response
		for (int i = 0; i < STALL_LOOPS; i++) begin
			value = $urandom;
			@(negedge clk);
			awaddr = SEVEN_SEG_ADDR;
			wdata = value;
			wstrb = 4'hF;
			awvalid = 1'b1;
			wvalid = 1'b1;
			araddr = SEVEN_SEG_ADDR;
			arvalid = 1'b1;
			@(posedge clk);
			while (!awready) @(posedge clk);
			@(negedge clk);
			awvalid = 1'b0;
			wvalid = 1'b0;
			repeat ($urandom_range(8, 3)) @(negedge clk);
			bready = 1'b1;
			@(posedge clk);
			while (!bvalid) @(posedge clk);
			@(negedge clk);
			bready = 1'b0;
			finishRead(readValue);
			checkWord("sevenSegment read after a stalled write", readValue, value);
		end

		@(negedge clk);
		$display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* files.f */
PeripheralPkg.sv
AxiLiteSlave.sv
AddressDecoder.sv
VideoBank.sv
ControlRegisters.sv
TimeBase.sv
ReadMux.sv
PeripheralBus.sv
PeripheralBusTb.sv

/* Makefile */
VERILATOR = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS = --binary --timing --assert -j 0
TOP = PeripheralBusTb
FILELIST = files.f
BUILD_DIR = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
